/* rvfi_pkg.sv */
`default_nettype none

package rvfi_pkg;

  // ----------------------------------------------------------
  // Widths
  // ----------------------------------------------------------
  localparam int unsigned Xlen            = 32;
  localparam int unsigned InstrWidth      = 32;
  localparam int unsigned RegAddrWidth    = 5;
  localparam int unsigned MaxTransIdWidth = 4;  // Room for up to 16 side-table entries

  // Environment-call exception causes
  localparam logic [31:0] EnvCallUmode = 32'd8;
  localparam logic [31:0] EnvCallSmode = 32'd9;
  localparam logic [31:0] EnvCallMmode = 32'd11;

  localparam int unsigned IntrCauseBit = 31;  // Set in cause for asynchronous events

  // Codes reported in the intr field of the retirement after a trap
  localparam logic [2:0] IntrAfterTrap = 3'd3;
  localparam logic [2:0] IntrAfterIrq  = 3'd5;

  // ----------------------------------------------------------
  // Enums
  // ----------------------------------------------------------
  typedef enum logic [1:0] {
    MEM_NONE,
    MEM_LOAD,
    MEM_STORE
  } mem_op_e;

  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_S = 2'd1,
    PRIV_M = 2'd3
  } priv_lvl_e;

  // ----------------------------------------------------------
  // Structs
  // ----------------------------------------------------------
  typedef struct packed {
    logic [InstrWidth-1:0] instr;
    logic                  is_compressed;
  } fetch_entry_t;

  typedef struct packed {
    logic                       valid;
    mem_op_e                    op;
    logic [MaxTransIdWidth-1:0] trans_id;
    logic [Xlen-1:0]            addr;
    logic [Xlen/8-1:0]          be;
    logic [Xlen-1:0]            wdata;
  } mem_access_t;

  typedef struct packed {
    logic                       valid;     // Retirement acked or exception reported
    logic [MaxTransIdWidth-1:0] trans_id;
    logic [Xlen-1:0]            pc;
    logic [RegAddrWidth-1:0]    rs1_addr;
    logic [RegAddrWidth-1:0]    rs2_addr;
    logic [RegAddrWidth-1:0]    rd_addr;
    logic [Xlen-1:0]            result;
    logic [Xlen-1:0]            wdata;
    logic                       ex_valid;
    logic [Xlen-1:0]            cause;
    priv_lvl_e                  priv;
  } commit_req_t;

  typedef struct packed {
    logic [Xlen-1:0]       rs1_rdata;
    logic [Xlen-1:0]       rs2_rdata;
    logic [InstrWidth-1:0] instr;
    logic [Xlen-1:0]       mem_addr;
    logic [Xlen/8-1:0]     mem_rmask;
    logic [Xlen/8-1:0]     mem_wmask;
    logic [Xlen-1:0]       mem_wdata;
  } sb_entry_t;

  typedef struct packed {
    logic                    valid;
    logic [InstrWidth-1:0]   insn;
    logic                    trap;
    logic [2:0]              intr;
    logic [Xlen-1:0]         cause;
    priv_lvl_e               mode;
    logic [RegAddrWidth-1:0] rs1_addr;
    logic [RegAddrWidth-1:0] rs2_addr;
    logic [RegAddrWidth-1:0] rd_addr;
    logic [Xlen-1:0]         rs1_rdata;
    logic [Xlen-1:0]         rs2_rdata;
    logic [Xlen-1:0]         rd_wdata;
    logic [Xlen-1:0]         pc_rdata;
    logic [Xlen-1:0]         mem_addr;
    logic [Xlen/8-1:0]       mem_rmask;
    logic [Xlen/8-1:0]       mem_wmask;
    logic [Xlen-1:0]         mem_rdata;
    logic [Xlen-1:0]         mem_wdata;
  } rvfi_instr_t;

endpackage

`default_nettype wire

/* rvfi_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rvfi_decode (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  flush_i,
  input  wire logic                  fetch_valid_i,
  input  wire rvfi_pkg::fetch_entry_t fetch_entry_i,
  output logic                       fetch_ready_o,
  output logic                       issue_valid_o,
  input  wire logic                  issue_ready_i,
  output rvfi_pkg::fetch_entry_t     issue_entry_o
);

  logic                   valid_q;
  rvfi_pkg::fetch_entry_t entry_q;
  rvfi_pkg::fetch_entry_t fetch_ext;  // Fetched entry with compressed opcode widened
  logic                   fetch_fire;
  logic                   issue_fire;

  // Register frees up when empty or when its content leaves this cycle
  assign issue_fire    = valid_q & issue_ready_i;
  assign fetch_ready_o = ~valid_q | issue_ready_i;
  assign fetch_fire    = fetch_valid_i & fetch_ready_o;

  always_comb begin
    fetch_ext = fetch_entry_i;
    if (fetch_entry_i.is_compressed) begin
      fetch_ext.instr = {16'b0, fetch_entry_i.instr[15:0]};  // Upper half carries no opcode
    end
  end

  // ----------------------------------------------------------
  // Holding register
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;  // Flush beats a fetch in the same cycle
    end else if (fetch_fire) begin
      valid_q <= 1'b1;
    end else if (issue_fire) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fetch_fire && !flush_i) begin
      entry_q <= fetch_ext;
    end
  end

  assign issue_valid_o = valid_q;
  assign issue_entry_o = entry_q;

  // Stalled issue keeps the same instruction on offer
  a_issue_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_o && !issue_ready_i && !flush_i |=> issue_valid_o && $stable(issue_entry_o));

endmodule

`default_nettype wire

/* rvfi_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module rvfi_execute #(
  parameter int unsigned NrSbEntries = 8
) (
  input  wire logic                           clk_i,
  input  wire logic                           rst_ni,
  input  wire logic                           issue_fire_i,
  input  wire rvfi_pkg::fetch_entry_t         issue_entry_i,
  input  wire logic [$clog2(NrSbEntries)-1:0] issue_trans_id_i,
  input  wire logic [rvfi_pkg::Xlen-1:0]      rs1_rdata_i,
  input  wire logic [rvfi_pkg::Xlen-1:0]      rs2_rdata_i,
  input  wire rvfi_pkg::mem_access_t          mem_access_i,
  input  wire logic [$clog2(NrSbEntries)-1:0] rd_trans_id_i,
  output rvfi_pkg::sb_entry_t                 rd_entry_o
);

  localparam int unsigned TransIdWidth = $clog2(NrSbEntries);

  rvfi_pkg::sb_entry_t [NrSbEntries-1:0] mem_q;
  rvfi_pkg::sb_entry_t [NrSbEntries-1:0] mem_d;
  logic [TransIdWidth-1:0]                mem_id;

  assign mem_id = mem_access_i.trans_id[TransIdWidth-1:0];  // Strobe id is sized for 16

  // ----------------------------------------------------------
  // Side table update
  // ----------------------------------------------------------
  always_comb begin
    mem_d = mem_q;

    // New issue starts with clean memory fields
    if (issue_fire_i) begin
      mem_d[issue_trans_id_i] = '{
        rs1_rdata: rs1_rdata_i,
        rs2_rdata: rs2_rdata_i,
        instr:     issue_entry_i.instr,
        default:   '0
      };
    end

    if (mem_access_i.valid) begin
      case (mem_access_i.op)
        rvfi_pkg::MEM_LOAD: begin
          mem_d[mem_id].mem_addr  = mem_access_i.addr;
          mem_d[mem_id].mem_rmask = mem_access_i.be;
        end
        rvfi_pkg::MEM_STORE: begin
          mem_d[mem_id].mem_addr  = mem_access_i.addr;
          mem_d[mem_id].mem_wmask = mem_access_i.be;
          mem_d[mem_id].mem_wdata = mem_access_i.wdata;
        end
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q <= '0;
    end else begin
      mem_q <= mem_d;
    end
  end

  assign rd_entry_o = mem_q[rd_trans_id_i];  // Old contents on a same-cycle write

  // LSU only strobes for real loads and stores
  a_mem_op_known : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_access_i.valid |-> mem_access_i.op != rvfi_pkg::MEM_NONE);

endmodule

`default_nettype wire

/* rvfi_result.sv */
`timescale 1ns/1ps
`default_nettype none

module rvfi_result #(
  parameter int unsigned NrSbEntries = 8
) (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire rvfi_pkg::commit_req_t     commit_i,
  output logic [$clog2(NrSbEntries)-1:0] rd_trans_id_o,
  input  wire rvfi_pkg::sb_entry_t       rd_entry_i,
  output rvfi_pkg::rvfi_instr_t          rvfi_o
);

  localparam int unsigned TransIdWidth = $clog2(NrSbEntries);

  logic                  exception;
  logic                  is_ecall;
  logic                  is_irq;
  logic                  retire;
  logic [2:0]            intr_q;
  logic                  valid_q;
  logic                  trap_q;
  rvfi_pkg::rvfi_instr_t rec_d;
  rvfi_pkg::rvfi_instr_t rec_q;

  assign rd_trans_id_o = commit_i.trans_id[TransIdWidth-1:0];

  // ----------------------------------------------------------
  // Retirement classification
  // ----------------------------------------------------------
  assign exception = commit_i.valid & commit_i.ex_valid;
  assign is_irq    = commit_i.cause[rvfi_pkg::IntrCauseBit];
  assign is_ecall  = (commit_i.cause == rvfi_pkg::EnvCallUmode) ||
                     (commit_i.cause == rvfi_pkg::EnvCallSmode) ||
                     (commit_i.cause == rvfi_pkg::EnvCallMmode);
  // Ecall still counts as an executed instruction
  assign retire    = (commit_i.valid & ~commit_i.ex_valid) | (exception & is_ecall);

  // Trap history seen by the next retirement
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      intr_q <= '0;
    end else if (exception && is_irq) begin
      intr_q <= rvfi_pkg::IntrAfterIrq;
    end else if (exception) begin
      intr_q <= rvfi_pkg::IntrAfterTrap;
    end else if (retire) begin
      intr_q <= '0;
    end
  end

  // ----------------------------------------------------------
  // Record build
  // ----------------------------------------------------------
  always_comb begin
    rec_d           = '0;
    rec_d.insn      = rd_entry_i.instr;
    rec_d.intr      = intr_q;  // Value before this commit's update
    rec_d.cause     = commit_i.cause;
    rec_d.mode      = commit_i.priv;
    rec_d.rs1_addr  = commit_i.rs1_addr;
    rec_d.rs2_addr  = commit_i.rs2_addr;
    rec_d.rd_addr   = commit_i.rd_addr;
    rec_d.rs1_rdata = rd_entry_i.rs1_rdata;
    rec_d.rs2_rdata = rd_entry_i.rs2_rdata;
    rec_d.rd_wdata  = commit_i.wdata;
    rec_d.pc_rdata  = commit_i.pc;
    rec_d.mem_addr  = rd_entry_i.mem_addr;
    rec_d.mem_rmask = rd_entry_i.mem_rmask;
    rec_d.mem_wmask = rd_entry_i.mem_wmask;
    rec_d.mem_rdata = commit_i.result;
    rec_d.mem_wdata = rd_entry_i.mem_wdata;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      trap_q  <= 1'b0;
    end else begin
      valid_q <= retire;
      trap_q  <= exception & ~is_irq;  // Synchronous trap only
    end
  end

  always_ff @(posedge clk_i) begin
    rec_q <= rec_d;
  end

  always_comb begin
    rvfi_o       = rec_q;
    rvfi_o.valid = valid_q;
    rvfi_o.trap  = trap_q;
  end

  // A reported trap never carries an interrupt cause
  a_trap_not_irq : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvfi_o.trap |-> !rvfi_o.cause[rvfi_pkg::IntrCauseBit]);

endmodule

`default_nettype wire

/* rvfi_tracer.sv */
`timescale 1ns/1ps
`default_nettype none

module rvfi_tracer #(
  parameter int unsigned NrSbEntries = 8
) (
  input  wire logic                           clk_i,
  input  wire logic                           rst_ni,
  input  wire logic                           flush_i,
  // Fetch
  input  wire logic                           fetch_valid_i,
  input  wire rvfi_pkg::fetch_entry_t         fetch_entry_i,
  output logic                                fetch_ready_o,
  // Issue
  output logic                                issue_valid_o,
  input  wire logic                           issue_ready_i,
  input  wire logic [$clog2(NrSbEntries)-1:0] issue_trans_id_i,
  input  wire logic [rvfi_pkg::Xlen-1:0]      rs1_rdata_i,
  input  wire logic [rvfi_pkg::Xlen-1:0]      rs2_rdata_i,
  // Memory and commit
  input  wire rvfi_pkg::mem_access_t          mem_access_i,
  input  wire rvfi_pkg::commit_req_t          commit_i,
  output rvfi_pkg::rvfi_instr_t               rvfi_o
);

  rvfi_pkg::fetch_entry_t           issue_entry;
  logic                             issue_fire;
  logic [$clog2(NrSbEntries)-1:0]   rd_trans_id;
  rvfi_pkg::sb_entry_t              rd_entry;

  assign issue_fire = issue_valid_o & issue_ready_i;  // Issue handshake

  rvfi_decode i_rvfi_decode (
    .clk_i,
    .rst_ni,
    .flush_i,
    .fetch_valid_i,
    .fetch_entry_i,
    .fetch_ready_o,
    .issue_valid_o,
    .issue_ready_i,
    .issue_entry_o (issue_entry)
  );

  rvfi_execute #(
    .NrSbEntries (NrSbEntries)
  ) i_rvfi_execute (
    .clk_i,
    .rst_ni,
    .issue_fire_i     (issue_fire),
    .issue_entry_i    (issue_entry),
    .issue_trans_id_i,
    .rs1_rdata_i,
    .rs2_rdata_i,
    .mem_access_i,
    .rd_trans_id_i    (rd_trans_id),
    .rd_entry_o       (rd_entry)
  );

  rvfi_result #(
    .NrSbEntries (NrSbEntries)
  ) i_rvfi_result (
    .clk_i,
    .rst_ni,
    .commit_i,
    .rd_trans_id_o (rd_trans_id),
    .rd_entry_i    (rd_entry),
    .rvfi_o
  );

endmodule

`default_nettype wire

/* tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int unsigned PeriodNs    = 8,
  parameter int unsigned ResetCycles = 10
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1 rst_no = 1'b1;  // Release off the edge
  end

endmodule

`default_nettype wire

/* tb_rvfi_tracer.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rvfi_tracer;

  localparam int unsigned NrSbEntries = 8;
  localparam int unsigned IdWidth     = $clog2(NrSbEntries);
  localparam int unsigned Timeout     = 40;  // Cycles allowed for any single wait

  logic                         clk;
  logic                         rst_n;
  logic                         flush;
  logic                         fetch_valid;
  logic                         fetch_ready;
  logic                         issue_valid;
  logic                         issue_ready;
  logic [IdWidth-1:0]           issue_id;
  logic [rvfi_pkg::Xlen-1:0]    rs1_rdata;
  logic [rvfi_pkg::Xlen-1:0]    rs2_rdata;
  rvfi_pkg::fetch_entry_t       fetch_entry;
  rvfi_pkg::mem_access_t        mem_access;
  rvfi_pkg::commit_req_t        commit;
  rvfi_pkg::rvfi_instr_t        rvfi;
  rvfi_pkg::rvfi_instr_t        exp_rec;  // Expected record for the last commit

  // Scoreboard model of the side table and the trap history
  rvfi_pkg::sb_entry_t          sb_model [NrSbEntries];
  logic [rvfi_pkg::InstrWidth-1:0] held_instr;
  logic [2:0]                   intr_model;
  logic [15:0]                  lfsr;
  int                           err_cnt;
  int                           test_cnt;
  int                           test_fail;

  tb_clock #(.PeriodNs(8), .ResetCycles(10)) i_clock (.clk_o(clk), .rst_no(rst_n));

  rvfi_tracer #(
    .NrSbEntries (NrSbEntries)
  ) i_rvfi_tracer (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .flush_i          (flush),
    .fetch_valid_i    (fetch_valid),
    .fetch_entry_i    (fetch_entry),
    .fetch_ready_o    (fetch_ready),
    .issue_valid_o    (issue_valid),
    .issue_ready_i    (issue_ready),
    .issue_trans_id_i (issue_id),
    .rs1_rdata_i      (rs1_rdata),
    .rs2_rdata_i      (rs2_rdata),
    .mem_access_i     (mem_access),
    .commit_i         (commit),
    .rvfi_o           (rvfi)
  );

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------
  a_reset_idle : assert property (@(posedge clk)
    $rose(rst_n) |-> !issue_valid && fetch_ready && !rvfi.valid && !rvfi.trap)
    else begin
      $display("ERROR t=%0t outputs were not idle right after reset release", $time);
      err_cnt++;
    end

  a_record : assert property (@(posedge clk) disable iff (!rst_n)
    commit.valid |=> rvfi === exp_rec)
    else begin
      $display("FAIL t=%0t rvfi_o exp=%h got=%h", $time, exp_rec, $sampled(rvfi));
      err_cnt++;
    end

  a_no_commit : assert property (@(posedge clk) disable iff (!rst_n)
    !commit.valid |=> !rvfi.valid && !rvfi.trap)
    else begin
      $display("ERROR t=%0t rvfi_o.valid or rvfi_o.trap rose without a commit", $time);
      err_cnt++;
    end

  a_stall_blocks_fetch : assert property (@(posedge clk) disable iff (!rst_n)
    issue_valid && !issue_ready |-> !fetch_ready)
    else begin
      $display("ERROR t=%0t fetch_ready_o high while the issue is stalled", $time);
      err_cnt++;
    end

  a_stall_holds : assert property (@(posedge clk) disable iff (!rst_n)
    issue_valid && !issue_ready && !flush |=> issue_valid)
    else begin
      $display("ERROR t=%0t held instruction was lost during a stall", $time);
      err_cnt++;
    end

  a_flush_drops : assert property (@(posedge clk) disable iff (!rst_n)
    flush |=> !issue_valid)
    else begin
      $display("ERROR t=%0t issue_valid_o still high after a flush", $time);
      err_cnt++;
    end

  a_idle_no_issue : assert property (@(posedge clk) disable iff (!rst_n)
    !fetch_valid && !issue_valid |=> !issue_valid)
    else begin
      $display("ERROR t=%0t issue_valid_o rose without a fetch", $time);
      err_cnt++;
    end

  a_empty_ready : assert property (@(posedge clk) disable iff (!rst_n)
    !issue_valid |-> fetch_ready)
    else begin
      $display("ERROR t=%0t fetch_ready_o low with an empty holding register", $time);
      err_cnt++;
    end

  // ------------------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------------------
  function automatic logic [31:0] lfsr_bits(input int unsigned n);
    logic [31:0] val;
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);  // Galois step
    end
    return val;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_issue_valid();
    int unsigned n;
    n = 0;
    while (!issue_valid && n < Timeout) begin
      next_cycle();
      n++;
    end
    if (!issue_valid) begin
      $display("ERROR t=%0t issue_valid_o did not rise within %0d cycles", $time, Timeout);
      err_cnt++;
    end
  endtask

  task automatic fetch_instr(input logic [31:0] instr, input logic compressed);
    int unsigned n;
    n           = 0;
    fetch_valid = 1'b1;
    fetch_entry = '{instr: instr, is_compressed: compressed};
    while (!fetch_ready && n < Timeout) begin
      next_cycle();
      n++;
    end
    if (!fetch_ready) begin
      $display("ERROR t=%0t fetch_ready_o did not rise within %0d cycles", $time, Timeout);
      err_cnt++;
    end
    next_cycle();
    fetch_valid = 1'b0;
    held_instr  = compressed ? {16'h0, instr[15:0]} : instr;  // Upper half dropped
  endtask

  task automatic issue_instr(input logic [IdWidth-1:0] id, input int unsigned stall);
    wait_issue_valid();
    repeat (stall) next_cycle();  // Back-pressure from the core
    issue_ready  = 1'b1;
    issue_id     = id;
    rs1_rdata    = lfsr_bits(32);
    rs2_rdata    = lfsr_bits(32);
    sb_model[id] = '{rs1_rdata: rs1_rdata, rs2_rdata: rs2_rdata, instr: held_instr,
                     default: '0};
    next_cycle();
    issue_ready = 1'b0;
  endtask

  task automatic mem_strobe(input logic [IdWidth-1:0] id, input rvfi_pkg::mem_op_e op);
    logic [31:0] rnd;
    rnd        = lfsr_bits(4);
    mem_access = '0;
    mem_access.valid                 = 1'b1;
    mem_access.op                    = op;
    mem_access.trans_id[IdWidth-1:0] = id;
    mem_access.addr                  = lfsr_bits(32);
    mem_access.be                    = rnd[3:0] | 4'h1;
    mem_access.wdata                 = lfsr_bits(32);
    sb_model[id].mem_addr = mem_access.addr;
    if (op == rvfi_pkg::MEM_LOAD) begin
      sb_model[id].mem_rmask = mem_access.be;
    end else begin
      sb_model[id].mem_wmask = mem_access.be;
      sb_model[id].mem_wdata = mem_access.wdata;
    end
    next_cycle();
    mem_access = '0;
  endtask

  // Drives one commit and builds the record that must follow it
  task automatic commit_instr(input logic [IdWidth-1:0] id, input logic ex,
                              input logic [31:0] cause);
    logic [31:0] rnd;
    logic        is_ecall;
    rnd      = lfsr_bits(15);
    is_ecall = (cause == rvfi_pkg::EnvCallUmode) || (cause == rvfi_pkg::EnvCallSmode) ||
               (cause == rvfi_pkg::EnvCallMmode);
    commit = '0;
    commit.valid                 = 1'b1;
    commit.trans_id[IdWidth-1:0] = id;
    commit.pc                    = lfsr_bits(32);
    commit.rs1_addr              = rnd[4:0];
    commit.rs2_addr              = rnd[9:5];
    commit.rd_addr               = rnd[14:10];
    commit.result                = lfsr_bits(32);
    commit.wdata                 = lfsr_bits(32);
    commit.ex_valid              = ex;
    commit.cause                 = cause;
    commit.priv                  = rvfi_pkg::PRIV_M;
    exp_rec = '0;
    exp_rec.valid     = !ex || is_ecall;
    exp_rec.trap      = ex && !cause[rvfi_pkg::IntrCauseBit];
    exp_rec.intr      = intr_model;
    exp_rec.insn      = sb_model[id].instr;
    exp_rec.cause     = cause;
    exp_rec.mode      = rvfi_pkg::PRIV_M;
    exp_rec.rs1_addr  = commit.rs1_addr;
    exp_rec.rs2_addr  = commit.rs2_addr;
    exp_rec.rd_addr   = commit.rd_addr;
    exp_rec.rs1_rdata = sb_model[id].rs1_rdata;
    exp_rec.rs2_rdata = sb_model[id].rs2_rdata;
    exp_rec.rd_wdata  = commit.wdata;
    exp_rec.pc_rdata  = commit.pc;
    exp_rec.mem_addr  = sb_model[id].mem_addr;
    exp_rec.mem_rmask = sb_model[id].mem_rmask;
    exp_rec.mem_wmask = sb_model[id].mem_wmask;
    exp_rec.mem_rdata = commit.result;
    exp_rec.mem_wdata = sb_model[id].mem_wdata;
    if (ex && cause[rvfi_pkg::IntrCauseBit]) begin
      intr_model = rvfi_pkg::IntrAfterIrq;
    end else if (ex) begin
      intr_model = rvfi_pkg::IntrAfterTrap;
    end else begin
      intr_model = '0;  // Plain retirement clears the history
    end
    next_cycle();
    commit = '0;
    next_cycle();  // a_record looks at rvfi_o on this edge
  endtask

  task automatic finish_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("Test %0d %s: passed", test_cnt, name);
    end else begin
      test_fail++;
      $display("Test %0d %s: failed with %0d errors", test_cnt, name, err_cnt - errs_before);
    end
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    int                 errs;
    int unsigned        n;
    logic [31:0]        rnd;
    logic [IdWidth-1:0] id;
    logic [IdWidth-1:0] ids [$];
    lfsr        = 16'd74;
    flush       = 1'b0;
    fetch_valid = 1'b0;
    fetch_entry = '0;
    issue_ready = 1'b0;
    issue_id    = '0;
    rs1_rdata   = '0;
    rs2_rdata   = '0;
    mem_access  = '0;
    commit      = '0;
    exp_rec     = '0;
    held_instr  = '0;
    intr_model  = '0;
    err_cnt     = 0;
    test_cnt    = 0;
    test_fail   = 0;
    n           = 0;
    foreach (sb_model[i]) sb_model[i] = '0;
    while (!rst_n && n < Timeout) begin
      next_cycle();
      n++;
    end
    if (!rst_n) begin
      $display("ERROR t=%0t reset was never released", $time);
      err_cnt++;
    end

    errs = err_cnt;
    repeat (20) next_cycle();  // Nothing may appear without stimulus
    finish_test("idle after reset", errs);

    errs = err_cnt;
    fetch_instr(32'hABCD_4501, 1'b1);
    issue_instr(3'd1, 0);
    fetch_instr(32'h0020_8133, 1'b0);
    issue_instr(3'd2, 0);
    commit_instr(3'd1, 1'b0, '0);
    commit_instr(3'd2, 1'b0, '0);
    finish_test("compressed and full instructions", errs);

    errs = err_cnt;
    for (int k = 0; k < 4; k++) begin
      rnd = lfsr_bits(IdWidth);
      id  = rnd[IdWidth-1:0];
      fetch_instr(lfsr_bits(32), 1'b0);
      issue_instr(id, (k == 1) ? 4 : 0);  // One stalled issue
      ids.push_back(id);
    end
    while (ids.size() > 0) begin
      commit_instr(ids.pop_front(), 1'b0, '0);
    end
    finish_test("random operands", errs);

    errs = err_cnt;
    fetch_instr(32'h0002_A303, 1'b0);
    issue_instr(3'd3, 0);
    fetch_instr(32'h0062_A023, 1'b0);
    issue_instr(3'd4, 0);
    mem_strobe(3'd3, rvfi_pkg::MEM_LOAD);
    mem_strobe(3'd4, rvfi_pkg::MEM_STORE);
    next_cycle();
    commit_instr(3'd3, 1'b0, '0);
    commit_instr(3'd4, 1'b0, '0);
    finish_test("load and store", errs);

    errs = err_cnt;
    fetch_instr(32'h1111_1113, 1'b0);
    wait_issue_valid();
    flush = 1'b1;
    next_cycle();
    flush = 1'b0;
    fetch_instr(32'h0040_0293, 1'b0);
    issue_instr(3'd5, 0);
    commit_instr(3'd5, 1'b0, '0);
    finish_test("flush", errs);

    errs = err_cnt;
    commit_instr(3'd5, 1'b1, rvfi_pkg::EnvCallMmode);
    commit_instr(3'd5, 1'b0, '0);
    commit_instr(3'd5, 1'b1, 32'd2);  // Illegal instruction
    commit_instr(3'd5, 1'b0, '0);
    commit_instr(3'd5, 1'b1, 32'h8000_0007);  // Timer interrupt
    commit_instr(3'd5, 1'b0, '0);
    commit_instr(3'd5, 1'b0, '0);
    finish_test("exceptions and interrupts", errs);

    $display("Tests run %0d, tests failed %0d, check errors %0d", test_cnt, test_fail,
             err_cnt);
    if (test_fail == 0 && err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
rvfi_pkg.sv
rvfi_decode.sv
rvfi_execute.sv
rvfi_result.sv
rvfi_tracer.sv
tb_clock.sv
tb_rvfi_tracer.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_rvfi_tracer
FILELIST  = sim.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
